//--- filelist.f
+incdir+.
mcu_pkg.sv
power_domain_ctrl.sv
irq_ctrl.sv
gpio_bank.sv
mini_mcu_top.sv
tb_mini_mcu.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_mini_mcu
RTL_TOP   ?= mini_mcu_top
FILELIST  ?= filelist.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_mini_mcu_ref.svh
// Reference functions and typed compare tasks for the mini MCU testbench.
// Included inside tb_mini_mcu after its error counters.
function automatic pwr_ctrl_out_t expected_pwr(input int step, input logic ret_n);
  pwr_ctrl_out_t p;
  // steps 0 on, 1..4 going off, 5 off, 6..8 coming back
  p.pwrgate_en_n   = !(step == 4 || step == 5);
  p.isogate_en_n   = !(step >= 2 && step <= 7);
  p.rst_n          = !(step >= 3 && step <= 6);
  p.clkgate_en_n   = (step == 0);
  p.retentive_en_n = ret_n;
  return p;
endfunction

function automatic logic [31:0] expected_irq(input logic [NUM_FAST_INTR-1:0] pend,
                                             input logic [NUM_FAST_INTR-1:0] en,
                                             input periph_intr_t p);
  logic [31:0] v;
  v = '0;
  v[3]     = p.software;
  v[7]     = p.timer[0];
  v[11]    = p.external;
  v[31:16] = pend & en;
  return v;
endfunction

task automatic check_pwr(input string name, input pwr_ctrl_out_t exp, input pwr_ctrl_out_t act);
  if (exp !== act) begin
    pwr_errs++;
    $display("MISMATCH %s expected %b actual %b", name, exp, act);
  end
endtask

task automatic check_pad(input string name, input pad_out_t exp, input pad_out_t act);
  if (exp !== act) begin
    pad_errs++;
    $display("MISMATCH %s expected %b actual %b", name, exp, act);
  end
endtask

task automatic check_irq(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (exp !== act) begin
    irq_errs++;
    $display("MISMATCH %s expected %h actual %h", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (exp !== act) begin
    bit_errs++;
    $display("MISMATCH %s expected %b actual %b", name, exp, act);
  end
endtask

//--- tb_mini_mcu.sv
// Testbench for mini_mcu_top. Exercises power sequencing with a switch model,
// fast interrupts and both GPIO banks against a cycle model.
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu
  import mcu_pkg::*;
;
  localparam int MAX_CYCLES = 3000;

  logic clk_i = 1'b0;
  logic reset_i;
  periph_intr_t periph_intr_i;
  logic [NUM_FAST_INTR-1:0] fast_en_i;
  logic irq_ack_i;
  logic [4:0] irq_id_i;
  logic [31:0] irq_o;
  gpio_ctrl_t [NUM_GPIO-1:0] gpio_ctrl_i;
  logic [NUM_GPIO-1:0] gpio_i;
  pad_out_t [NUM_GPIO-1:0] gpio_pad_o;
  logic [NUM_GPIO-1:0] gpio_in_o;
  logic [NUM_DOMAINS-1:0] domain_off_req_i;
  logic core_sleep_i;
  logic [1:0] bank_retain_i;
  pwr_ctrl_in_t [NUM_DOMAINS-1:0] pwr_ack_i;
  pwr_ctrl_out_t [NUM_DOMAINS-1:0] pwr_ctrl_o;

  int pwr_errs = 0;
  int pad_errs = 0;
  int irq_errs = 0;
  int bit_errs = 0;
  int cycle_cnt = 0;
  integer seed = 32'hbd5d;

  // cycle model state
  int step_m [NUM_DOMAINS];
  logic [NUM_DOMAINS-1:0] ret_n_m;
  logic [NUM_FAST_INTR-1:0] pend_m;
  pad_out_t [NUM_GPIO-1:0] pad_m;
  logic [NUM_GPIO-1:0] s1_m;
  logic [NUM_GPIO-1:0] s2_m;
  logic [NUM_GPIO-1:0] prev_m;
  int ack_cnt [NUM_DOMAINS];

  `include "tb_mini_mcu_ref.svh"

  mini_mcu_top i_mini_mcu_top (.*);

  always #50 clk_i = ~clk_i;

  // ack follows pwrgate_en_n after 1 to 5 cycles
  always @(posedge clk_i) begin
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      if (ack_cnt[d] > 1) begin
        ack_cnt[d] <= ack_cnt[d] - 1;
      end else if (ack_cnt[d] == 1) begin
        ack_cnt[d] <= 0;
        pwr_ack_i[d].pwrgate_ack_n <= pwr_ctrl_o[d].pwrgate_en_n;
      end else if (pwr_ctrl_o[d].pwrgate_en_n != pwr_ack_i[d].pwrgate_ack_n) begin
        ack_cnt[d] <= 1 + ($unsigned($random(seed)) % 5);
      end
    end
  end

  // model update with the inputs seen at the edge
  always @(posedge clk_i) begin
    logic req;
    logic [NUM_FAST_INTR-1:0] src;
    logic [NUM_FAST_INTR-1:0] clr;
    src = {periph_intr_i.ext_periph, periph_intr_i.dma_window,
           s2_m[NUM_GPIO_AO-1:0] & ~prev_m[NUM_GPIO_AO-1:0],
           periph_intr_i.spi_flash, periph_intr_i.spi, periph_intr_i.dma_done,
           periph_intr_i.timer[3:1]};
    clr = '0;
    if (irq_ack_i && irq_id_i >= 16) begin
      clr[irq_id_i - 16] = 1'b1;
    end
    for (int i = 0; i < NUM_GPIO; i++) begin
      pad_m[i].o  = gpio_ctrl_i[i].o;
      pad_m[i].oe = reset_i ? 1'b0 : gpio_ctrl_i[i].dir;
    end
    if (reset_i) begin
      pend_m = '0;
      s1_m = '0;
      s2_m = '0;
      prev_m = '0;
      ret_n_m = '1;
      for (int d = 0; d < NUM_DOMAINS; d++) step_m[d] = 0;
    end else begin
      pend_m = (pend_m & ~clr) | src;
      prev_m = s2_m;
      s2_m = s1_m;
      s1_m = gpio_i;
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        req = domain_off_req_i[d] && (d != DOM_CPU || core_sleep_i);
        case (step_m[d])
          0: if (req) step_m[d] = 1;
          4: if (!pwr_ack_i[d].pwrgate_ack_n) step_m[d] = 5;
          5: if (!req) step_m[d] = 6;
          6: if (pwr_ack_i[d].pwrgate_ack_n) step_m[d] = 7;
          8: step_m[d] = 0;
          default: step_m[d] = step_m[d] + 1;
        endcase
        ret_n_m[d] = (d == DOM_BANK0 || d == DOM_BANK1) ? ~bank_retain_i[d-DOM_BANK0] : 1'b1;
      end
    end
  end

  // compare against the model in mid cycle
  always @(negedge clk_i) begin
    if (!reset_i) begin
      for (int d = 0; d < NUM_DOMAINS; d++) begin
        check_pwr($sformatf("pwr_dom%0d", d), expected_pwr(step_m[d], ret_n_m[d]),
                  pwr_ctrl_o[d]);
      end
      for (int i = 0; i < NUM_GPIO; i++) begin
        check_pad($sformatf("pad%0d", i), pad_m[i], gpio_pad_o[i]);
        check_bit($sformatf("gpio_in%0d", i), s2_m[i], gpio_in_o[i]);
      end
      check_irq("irq", expected_irq(pend_m, fast_en_i, periph_intr_i), irq_o);
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  task automatic power_cycle(input int d, input bit early_release);
    @(posedge clk_i);
    domain_off_req_i[d] <= 1'b1;
    do @(posedge clk_i); while (pwr_ctrl_o[d].pwrgate_en_n);
    // an early release still has to wait for the switch to report off
    if (!early_release) begin
      do @(posedge clk_i); while (pwr_ack_i[d].pwrgate_ack_n);
      repeat (2) @(posedge clk_i);
    end
    domain_off_req_i[d] <= 1'b0;
    do @(posedge clk_i); while (!pwr_ctrl_o[d].clkgate_en_n);
  endtask

  initial begin
    reset_i <= 1'b1;
    periph_intr_i <= '0;
    fast_en_i <= '1;
    irq_ack_i <= 1'b0;
    irq_id_i <= '0;
    gpio_ctrl_i <= '0;
    gpio_i <= '0;
    domain_off_req_i <= '0;
    core_sleep_i <= 1'b0;
    bank_retain_i <= '0;
    pwr_ack_i <= '1;
    for (int d = 0; d < NUM_DOMAINS; d++) ack_cnt[d] = 0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_irq("reset_irq", 32'h0, irq_o);
    check_bit("reset_oe", 1'b0, gpio_pad_o[0].oe);
    check_pwr("reset_pwr", '1, pwr_ctrl_o[DOM_EXT]);

    // cpu request without sleep must not move
    @(posedge clk_i);
    domain_off_req_i[DOM_CPU] <= 1'b1;
    repeat (10) @(posedge clk_i);
    domain_off_req_i[DOM_CPU] <= 1'b0;
    core_sleep_i <= 1'b1;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      power_cycle(d, 1'b0);
      power_cycle(d, 1'b1);
    end
    @(posedge clk_i);
    core_sleep_i <= 1'b0;

    for (int r = 1; r < 4; r++) begin
      @(posedge clk_i);
      bank_retain_i <= r[1:0];
      repeat (5) @(posedge clk_i);
    end
    @(negedge clk_i);
    check_bit("retain_bank0", 1'b0, pwr_ctrl_o[DOM_BANK0].retentive_en_n);
    check_bit("retain_periph", 1'b1, pwr_ctrl_o[DOM_PERIPH].retentive_en_n);
    @(posedge clk_i);
    bank_retain_i <= '0;

    // random interrupt sources, acks and gpio traffic
    repeat (600) begin
      @(posedge clk_i);
      periph_intr_i <= 13'($random(seed) & $random(seed)) & 13'h1ffc;
      fast_en_i <= NUM_FAST_INTR'($random(seed));
      irq_ack_i <= 1'($random(seed));
      irq_id_i <= 5'd16 + 5'($unsigned($random(seed)) % 16);
      gpio_ctrl_i <= {$random(seed), $random(seed)};
      gpio_i <= $random(seed);
    end

    // set wins over clear and a later ack clears
    @(posedge clk_i);
    periph_intr_i <= '0;
    periph_intr_i.timer <= 4'b0010;
    fast_en_i <= '1;
    irq_ack_i <= 1'b1;
    irq_id_i <= 5'd16;
    @(posedge clk_i);
    periph_intr_i <= '0;
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
    check_bit("set_wins", 1'b1, irq_o[16]);
    @(posedge clk_i);
    irq_ack_i <= 1'b1;
    @(posedge clk_i);
    irq_ack_i <= 1'b0;
    @(negedge clk_i);
    check_bit("ack_clear", 1'b0, irq_o[16]);

    @(posedge clk_i);
    periph_intr_i.software <= 1'b1;
    periph_intr_i.timer <= 4'b0001;
    periph_intr_i.external <= 1'b1;
    @(negedge clk_i);
    check_bit("software", 1'b1, irq_o[3]);
    check_bit("timer", 1'b1, irq_o[7]);
    check_bit("external", 1'b1, irq_o[11]);
    repeat (4) @(posedge clk_i);

    $display("errors: pwr %0d pad %0d irq %0d bit %0d", pwr_errs, pad_errs, irq_errs, bit_errs);
    if (pwr_errs + pad_errs + irq_errs + bit_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mini_mcu_top.sv
// Integration level of the mini MCU: domain power sequencers, interrupt
// assembly and the always-on and main GPIO banks.
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_top
  import mcu_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            reset_i,

  // interrupts
  input  periph_intr_t                    periph_intr_i,
  input  logic          [NUM_FAST_INTR-1:0] fast_en_i,
  input  logic                            irq_ack_i,
  input  logic          [4:0]             irq_id_i,
  output logic          [31:0]            irq_o,

  // gpio
  input  gpio_ctrl_t    [NUM_GPIO-1:0]    gpio_ctrl_i,
  input  logic          [NUM_GPIO-1:0]    gpio_i,
  output pad_out_t      [NUM_GPIO-1:0]    gpio_pad_o,
  output logic          [NUM_GPIO-1:0]    gpio_in_o,

  // power control
  input  logic          [NUM_DOMAINS-1:0] domain_off_req_i,
  input  logic                            core_sleep_i,
  input  logic          [1:0]             bank_retain_i,
  input  pwr_ctrl_in_t  [NUM_DOMAINS-1:0] pwr_ack_i,
  output pwr_ctrl_out_t [NUM_DOMAINS-1:0] pwr_ctrl_o
);

  logic [NUM_FAST_INTR-1:0] fast_src;
  logic [NUM_GPIO_AO-1:0]   gpio_ao_intr;

  // fast lines from bit 0: timer 1..3, dma, spi, flash, ao gpio, window, ext
  assign fast_src = {
    periph_intr_i.ext_periph,
    periph_intr_i.dma_window,
    gpio_ao_intr,
    periph_intr_i.spi_flash,
    periph_intr_i.spi,
    periph_intr_i.dma_done,
    periph_intr_i.timer[3],
    periph_intr_i.timer[2],
    periph_intr_i.timer[1]
  };

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : gen_domain
    if (d == DOM_CPU) begin : gen_cpu
      // core may only be gated while it sleeps
      power_domain_ctrl #(
        .RETENTION(0)
      ) i_power_domain_ctrl (
        .clk_i,
        .reset_i,
        .off_req_i   (domain_off_req_i[d] & core_sleep_i),
        .retain_req_i(1'b0),
        .pwr_ack_i   (pwr_ack_i[d]),
        .pwr_ctrl_o  (pwr_ctrl_o[d])
      );
    end else if (d == DOM_BANK0 || d == DOM_BANK1) begin : gen_bank
      power_domain_ctrl #(
        .RETENTION(1)
      ) i_power_domain_ctrl (
        .clk_i,
        .reset_i,
        .off_req_i   (domain_off_req_i[d]),
        .retain_req_i(bank_retain_i[d-DOM_BANK0]),
        .pwr_ack_i   (pwr_ack_i[d]),
        .pwr_ctrl_o  (pwr_ctrl_o[d])
      );
    end else begin : gen_plain
      power_domain_ctrl #(
        .RETENTION(0)
      ) i_power_domain_ctrl (
        .clk_i,
        .reset_i,
        .off_req_i   (domain_off_req_i[d]),
        .retain_req_i(1'b0),
        .pwr_ack_i   (pwr_ack_i[d]),
        .pwr_ctrl_o  (pwr_ctrl_o[d])
      );
    end
  end

  irq_ctrl i_irq_ctrl (
    .clk_i,
    .reset_i,
    .fast_src_i(fast_src),
    .fast_en_i,
    .timer_i   (periph_intr_i.timer[0]),
    .external_i(periph_intr_i.external),
    .software_i(periph_intr_i.software),
    .irq_ack_i,
    .irq_id_i,
    .irq_o
  );

  // always-on bank, low pins
  gpio_bank #(
    .NUM_PINS(NUM_GPIO_AO)
  ) i_gpio_bank_ao (
    .clk_i,
    .reset_i,
    .ctrl_i(gpio_ctrl_i[NUM_GPIO_AO-1:0]),
    .pad_i (gpio_i[NUM_GPIO_AO-1:0]),
    .pad_o (gpio_pad_o[NUM_GPIO_AO-1:0]),
    .in_o  (gpio_in_o[NUM_GPIO_AO-1:0]),
    .intr_o(gpio_ao_intr)
  );

  // main bank has no edge interrupts in use
  gpio_bank #(
    .NUM_PINS(NUM_GPIO - NUM_GPIO_AO)
  ) i_gpio_bank_main (
    .clk_i,
    .reset_i,
    .ctrl_i(gpio_ctrl_i[NUM_GPIO-1:NUM_GPIO_AO]),
    .pad_i (gpio_i[NUM_GPIO-1:NUM_GPIO_AO]),
    .pad_o (gpio_pad_o[NUM_GPIO-1:NUM_GPIO_AO]),
    .in_o  (gpio_in_o[NUM_GPIO-1:NUM_GPIO_AO]),
    .intr_o()
  );

endmodule

`default_nettype wire

//--- gpio_bank.sv
// One bank of GPIO pins with registered pad drive, a two-stage input
// synchronizer and a rising-edge interrupt per pin.
`timescale 1ns/1ps
`default_nettype none

module gpio_bank
  import mcu_pkg::*;
#(
  parameter int NUM_PINS = 8
) (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  gpio_ctrl_t [NUM_PINS-1:0]     ctrl_i,
  input  logic       [NUM_PINS-1:0]     pad_i,
  output pad_out_t   [NUM_PINS-1:0]     pad_o,
  output logic       [NUM_PINS-1:0]     in_o,
  output logic       [NUM_PINS-1:0]     intr_o
);

  logic [NUM_PINS-1:0] sync_q1;
  logic [NUM_PINS-1:0] sync_q2;
  logic [NUM_PINS-1:0] prev_q;

  // registered pad drive
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_PINS; i++) begin
      pad_o[i].o <= ctrl_i[i].o;
      if (reset_i) begin
        pad_o[i].oe <= 1'b0;
      end else begin
        pad_o[i].oe <= ctrl_i[i].dir;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      prev_q  <= '0;
    end else begin
      sync_q1 <= pad_i;
      sync_q2 <= sync_q1;
      prev_q  <= sync_q2;
    end
  end

  assign in_o = sync_q2;

  // 0 to 1 on the synchronized input
  assign intr_o = sync_q2 & ~prev_q;

endmodule

`default_nettype wire

//--- irq_ctrl.sv
// Fast-interrupt pending register and core interrupt vector assembly.
// Pending bits are sticky until the core acknowledges their id.
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
  import mcu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [NUM_FAST_INTR-1:0] fast_src_i,
  input  logic [NUM_FAST_INTR-1:0] fast_en_i,
  input  logic                     timer_i,
  input  logic                     external_i,
  input  logic                     software_i,
  input  logic                     irq_ack_i,
  input  logic [4:0]               irq_id_i,
  output logic [31:0]              irq_o
);

  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] pending_clr;

  // ack decode, one bit per fast line
  always_comb begin
    for (int k = 0; k < NUM_FAST_INTR; k++) begin
      pending_clr[k] = irq_ack_i && (irq_id_i == 5'(FAST_INTR_BASE + k));
    end
  end

  // set has priority over clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~pending_clr) | fast_src_i;
    end
  end

  always_comb begin
    irq_o                                  = '0;
    irq_o[IRQ_SOFTWARE]                    = software_i;
    irq_o[IRQ_TIMER]                       = timer_i;
    irq_o[IRQ_EXTERNAL]                    = external_i;
    irq_o[FAST_INTR_BASE +: NUM_FAST_INTR] = pending_q & fast_en_i;
  end

endmodule

`default_nettype wire

//--- power_domain_ctrl.sv
// Power sequencer for a single domain. Turns the domain off in the order
// clock gate, isolation, reset, switch and back on in reverse.
`timescale 1ns/1ps
`default_nettype none

module power_domain_ctrl
  import mcu_pkg::*;
#(
  parameter int RETENTION = 0
) (
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          off_req_i,
  input  logic          retain_req_i,
  input  pwr_ctrl_in_t  pwr_ack_i,
  output pwr_ctrl_out_t pwr_ctrl_o
);

  typedef enum logic [3:0] {
    ON,
    CLK_OFF,
    ISO_ON,
    RST_ON,
    SW_OFF_WAIT,
    OFF,
    SW_ON_WAIT,
    RST_OFF,
    ISO_OFF
  } state_e;

  state_e state_q;
  state_e state_d;

  pwr_ctrl_out_t ctrl_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ON:          if (off_req_i) state_d = CLK_OFF;
      CLK_OFF:     state_d = ISO_ON;
      ISO_ON:      state_d = RST_ON;
      RST_ON:      state_d = SW_OFF_WAIT;
      // switch reports off with ack low
      SW_OFF_WAIT: if (!pwr_ack_i.pwrgate_ack_n) state_d = OFF;
      OFF:         if (!off_req_i) state_d = SW_ON_WAIT;
      SW_ON_WAIT:  if (pwr_ack_i.pwrgate_ack_n) state_d = RST_OFF;
      RST_OFF:     state_d = ISO_OFF;
      ISO_OFF:     state_d = ON;
      default:     state_d = ON;
    endcase
  end

  // output decode of the next state
  always_comb begin
    ctrl_d.pwrgate_en_n   = 1'b1;
    ctrl_d.isogate_en_n   = 1'b1;
    ctrl_d.rst_n          = 1'b1;
    ctrl_d.clkgate_en_n   = 1'b1;
    ctrl_d.retentive_en_n = 1'b1;
    case (state_d)
      CLK_OFF: begin
        ctrl_d.clkgate_en_n = 1'b0;
      end
      ISO_ON: begin
        ctrl_d.clkgate_en_n = 1'b0;
        ctrl_d.isogate_en_n = 1'b0;
      end
      RST_ON, SW_ON_WAIT: begin
        ctrl_d.clkgate_en_n = 1'b0;
        ctrl_d.isogate_en_n = 1'b0;
        ctrl_d.rst_n        = 1'b0;
      end
      SW_OFF_WAIT, OFF: begin
        ctrl_d.clkgate_en_n = 1'b0;
        ctrl_d.isogate_en_n = 1'b0;
        ctrl_d.rst_n        = 1'b0;
        ctrl_d.pwrgate_en_n = 1'b0;
      end
      RST_OFF: begin
        ctrl_d.clkgate_en_n = 1'b0;
        ctrl_d.isogate_en_n = 1'b0;
      end
      ISO_OFF: begin
        ctrl_d.clkgate_en_n = 1'b0;
      end
      default: begin
        ctrl_d.clkgate_en_n = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ON;
      pwr_ctrl_o <= '1;
    end else begin
      state_q                 <= state_d;
      pwr_ctrl_o.pwrgate_en_n <= ctrl_d.pwrgate_en_n;
      pwr_ctrl_o.isogate_en_n <= ctrl_d.isogate_en_n;
      pwr_ctrl_o.rst_n        <= ctrl_d.rst_n;
      pwr_ctrl_o.clkgate_en_n <= ctrl_d.clkgate_en_n;
      // retention only exists in memory banks
      if (RETENTION != 0) begin
        pwr_ctrl_o.retentive_en_n <= ~retain_req_i;
      end else begin
        pwr_ctrl_o.retentive_en_n <= ctrl_d.retentive_en_n;
      end
    end
  end

endmodule

`default_nettype wire

//--- mcu_pkg.sv
// Shared sizes, interrupt bit positions and record types for the mini MCU.
// Imported by every RTL module and by the testbench.
`default_nettype none

package mcu_pkg;

  // power domains
  localparam int NUM_DOMAINS = 5;
  localparam int DOM_CPU     = 0;
  localparam int DOM_PERIPH  = 1;
  localparam int DOM_BANK0   = 2;
  localparam int DOM_BANK1   = 3;
  localparam int DOM_EXT     = 4;

  // gpio pins, low pins form the always-on bank
  localparam int NUM_GPIO    = 32;
  localparam int NUM_GPIO_AO = 8;

  // core interrupt vector layout
  localparam int NUM_FAST_INTR  = 16;
  localparam int FAST_INTR_BASE = 16;
  localparam int IRQ_SOFTWARE   = 3;
  localparam int IRQ_TIMER      = 7;
  localparam int IRQ_EXTERNAL   = 11;

  // all fields active low
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_ctrl_out_t;

  typedef struct packed {
    logic pwrgate_ack_n;
  } pwr_ctrl_in_t;

  typedef struct packed {
    logic o;
    logic oe;
  } pad_out_t;

  // dir high drives the pad
  typedef struct packed {
    logic o;
    logic dir;
  } gpio_ctrl_t;

  // levels from peripherals outside this design
  typedef struct packed {
    logic [3:0] timer;
    logic       dma_done;
    logic       dma_window;
    logic       spi_flash;
    logic       spi;
    logic       ext_periph;
    logic       external;
    logic       software;
    logic [1:0] reserved;
  } periph_intr_t;

endpackage

`default_nettype wire
